/* tests/cache_tests.txt */
# op addr wdata expected_rdata read_bursts write_bursts (hex hex hex hex dec dec)
# wdata unused for R, expected_rdata unused for W; unwritten memory reads addr ^ c0de0000
R 00000010 00000000 c0de0010 1 0
R 00000013 00000000 c0de0013 0 0
W 00000011 12345678 00000000 0 0
R 00000011 00000000 12345678 0 0
# write miss into set 8
W 00000020 aabbccdd 00000000 1 0
R 00000022 00000000 c0de0022 0 0
R 00000020 00000000 aabbccdd 0 0
# set 12 lines A=030 B=130 C=230 D=330
W 00000031 0badf00d 00000000 1 0
R 00000132 00000000 c0de0132 1 0
R 00000230 00000000 c0de0230 1 1
R 00000031 00000000 0badf00d 1 0
R 00000033 00000000 c0de0033 0 0
R 00000232 00000000 c0de0232 0 0
W 00000332 5a5a5a5a 00000000 1 0
R 00000130 00000000 c0de0130 1 0
R 00000030 00000000 c0de0030 1 1
R 00000332 00000000 5a5a5a5a 1 0
R 00000011 00000000 12345678 0 0
# high tag bits
R ffffff03 00000000 3f21ff03 1 0
R ffffff01 00000000 3f21ff01 0 0

/* files.f */
design/cache_pkg.sv
design/tag_store.sv
design/data_store.sv
design/mem_burst.sv
design/cache_fsm.sv
design/cache_top.sv
tests/tb_clock.sv
tests/cache_tb.sv

/* Bender.yml */
package:
  name: cache_ctrl

sources:
  - design/cache_pkg.sv
  - design/tag_store.sv
  - design/data_store.sv
  - design/mem_burst.sv
  - design/cache_fsm.sv
  - design/cache_top.sv
  - target: test
    files:
      - tests/tb_clock.sv
      - tests/cache_tb.sv

/* tests/cache_tb.sv */
`default_nettype none

module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct {
		byte              op;
		cache_pkg::addr_t addr;
		cache_pkg::word_t wdata;
		cache_pkg::word_t rdata;
		int               rd_bursts;
		int               wr_bursts;
	} test_op_t;

	logic             clk;
	logic             reset;
	cache_pkg::addr_t addr_up;
	cache_pkg::word_t data_up;
	logic             read_up;
	logic             write_up;
	cache_pkg::word_t data_mem;
	logic             ready_mem;
	cache_pkg::word_t rdata_up;
	logic             stall_up;
	cache_pkg::addr_t addr_mem;
	cache_pkg::word_t wdata_mem;
	logic             read_mem;
	logic             write_mem;

	cache_pkg::word_t mem [cache_pkg::addr_t];	// only words written back
	test_op_t         ops [$];
	int               rd_bursts;
	int               wr_bursts;
	logic             tests_loaded = 1'b0;
	cache_pkg::word_t last_rdata;
	cache_pkg::addr_t line_addr;	// line of the request in flight

	tb_clock clock_i (.clk, .reset);

	cache_top dut_i (
		.clk, .reset,
		.addr_up, .data_up, .read_up, .write_up,
		.data_mem, .ready_mem,
		.rdata_up, .stall_up,
		.addr_mem, .wdata_mem, .read_mem, .write_mem
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("** FAIL **");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input cache_pkg::word_t got,
		input cache_pkg::word_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run("word check failed");
		end
	endtask

	task automatic check_addr(input string name, input cache_pkg::addr_t got,
		input cache_pkg::addr_t exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run("address check failed");
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp);
			abort_run("count check failed");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
			abort_run("level check failed");
		end
	endtask

	// unwritten words follow the address
	function automatic cache_pkg::word_t mem_read(input cache_pkg::addr_t a);
		if (mem.exists(a))
			return mem[a];
		return a ^ 32'hc0de0000;
	endfunction

	task automatic load_tests();
		int       fd;
		int       n;
		string    line;
		test_op_t t;
		fd = $fopen("tests/cache_tests.txt", "r");
		if (fd == 0) begin
			abort_run("cannot open tests/cache_tests.txt");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() >= 2 && line.getc(0) != "#") begin
					t.op = line.getc(0);
					n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %d %d",
						t.addr, t.wdata, t.rdata, t.rd_bursts, t.wr_bursts);
					if (n == 5 && (t.op == "R" || t.op == "W"))
						ops.push_back(t);
					else
						abort_run($sformatf("bad line in test file: %s", line));
				end
			end
			$fclose(fd);
			if (ops.size() == 0)
				abort_run("test file holds no operations");
		end
	endtask

	task automatic run_op(input test_op_t t);
		int stall_cycles;
		int rd_start;
		int wr_start;
		rd_start = rd_bursts;
		wr_start = wr_bursts;
		line_addr = {t.addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS],
			{cache_pkg::OFFSET_BITS{1'b0}}};
		addr_up  = t.addr;
		data_up  = t.wdata;
		read_up  = (t.op == "R");
		write_up = (t.op == "W");
		@(posedge clk);
		#1;
		read_up  = 1'b0;	// one-cycle request pulse
		write_up = 1'b0;
		check_bit("stall_up", stall_up, 1'b1);
		stall_cycles = 1;
		while (stall_up) begin
			check_word("rdata_up", rdata_up, last_rdata);	// held while stalled
			@(posedge clk);
			#1;
			if (stall_up)
				stall_cycles++;
		end
		if (t.op == "R")
			last_rdata = t.rdata;
		check_word("rdata_up", rdata_up, last_rdata);
		check_count("read bursts", rd_bursts - rd_start, t.rd_bursts);
		check_count("write bursts", wr_bursts - wr_start, t.wr_bursts);
		if (t.rd_bursts == 0 && t.wr_bursts == 0)
			check_count("stall_up cycles", stall_cycles, 1);	// a hit
	endtask

	// memory model, sampled at the edge and driven 1 ns later
	initial begin
		int   word_i;
		logic prev_read;
		logic prev_write;
		void'($urandom(32'h493eca41));
		data_mem   = '0;
		ready_mem  = 1'b0;
		rd_bursts  = 0;
		wr_bursts  = 0;
		word_i     = 0;
		prev_read  = 1'b0;
		prev_write = 1'b0;
		forever begin
			@(posedge clk);
			if (read_mem === 1'b1)
				check_addr("addr_mem", addr_mem, line_addr);	// fill of the request line
			if (write_mem === 1'b1)
				check_addr("addr_mem", addr_mem,
					{addr_mem[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS+cache_pkg::INDEX_BITS],
					line_addr[cache_pkg::OFFSET_BITS+cache_pkg::INDEX_BITS-1:0]});
			if (read_mem === 1'b1 && !prev_read)
				rd_bursts++;
			if (write_mem === 1'b1 && !prev_write)
				wr_bursts++;
			prev_read  = (read_mem === 1'b1);
			prev_write = (write_mem === 1'b1);
			if (!prev_read && !prev_write)
				word_i = 0;
			else if (ready_mem) begin
				if (prev_write)
					mem[cache_pkg::addr_t'(addr_mem + word_i)] = wdata_mem;
				word_i++;
			end
			#1;
			ready_mem = ($urandom % 4) != 0;	// high 3 cycles in 4
			if (read_mem === 1'b1)
				data_mem = mem_read(cache_pkg::addr_t'(addr_mem + word_i));
			else
				data_mem = '0;
		end
	end

	initial begin
		wait (tests_loaded);
		repeat (ops.size() * 60 + 10) @(posedge clk);
		abort_run($sformatf("timeout: %0d operations did not complete", ops.size()));
	end

	initial begin
		addr_up    = '0;
		data_up    = '0;
		read_up    = 1'b0;
		write_up   = 1'b0;
		last_rdata = '0;
		line_addr  = '0;
		load_tests();
		tests_loaded = 1'b1;
		@(posedge reset);
		@(posedge clk);
		#1;
		check_word("rdata_up", rdata_up, '0);	// reset values
		check_bit("stall_up", stall_up, 1'b0);
		check_bit("read_mem", read_mem, 1'b0);
		check_bit("write_mem", write_mem, 1'b0);
		foreach (ops[i])
			run_op(ops[i]);
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`default_nettype none

module tb_clock (
	output logic clk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 1ps;

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;	// 8 ns period
	end

	// low for five rising edges, released just after the fifth
	initial begin
		reset = 1'b0;
		repeat (5) @(posedge clk);
		#1 reset = 1'b1;
	end

endmodule

`default_nettype wire

/* design/cache_top.sv */
`default_nettype none

module cache_top (
	input  wire                clk,
	input  wire                reset,
	input  wire cache_pkg::addr_t addr_up,
	input  wire cache_pkg::word_t data_up,
	input  wire                read_up,
	input  wire                write_up,
	input  wire cache_pkg::word_t data_mem,
	input  wire                ready_mem,
	output cache_pkg::word_t   rdata_up,
	output logic               stall_up,
	output cache_pkg::addr_t   addr_mem,
	output cache_pkg::word_t   wdata_mem,
	output logic               read_mem,
	output logic               write_mem
);

	cache_pkg::index_t  lookup_index;
	logic               hit;
	cache_pkg::way_t    hit_way;
	cache_pkg::way_t    victim_way;
	logic               victim_dirty;
	cache_pkg::tag_t    victim_tag;

	logic               tag_we;
	cache_pkg::way_t    tag_way;
	cache_pkg::tag_t    new_tag;		// also the tag under lookup
	logic               new_dirty;

	logic               data_we;
	cache_pkg::way_t    data_way;
	logic               data_word_only;
	cache_pkg::offset_t data_offset;
	cache_pkg::line_t   data_line;
	cache_pkg::line_t   rd_line0;
	cache_pkg::line_t   rd_line1;

	logic               evict_start;
	logic               fill_start;
	cache_pkg::addr_t   burst_addr;
	cache_pkg::line_t   evict_line;
	cache_pkg::line_t   fill_line;
	logic               burst_done;

	cache_fsm fsm_i (
		.clk, .reset,
		.addr_up, .data_up, .read_up, .write_up,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.rd_line0, .rd_line1, .fill_line, .burst_done,
		.rdata_up, .stall_up, .lookup_index,
		.tag_we, .tag_way, .new_tag, .new_dirty,
		.data_we, .data_way, .data_word_only, .data_offset, .data_line,
		.evict_start, .fill_start, .burst_addr, .evict_line
	);

	tag_store tags_i (
		.clk, .reset, .lookup_index,
		.lookup_tag (new_tag),
		.tag_we, .tag_way, .new_tag, .new_dirty,
		.hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	// on a word write every word of data_line carries the write data
	data_store data_i (
		.clk, .lookup_index,
		.data_we, .data_way, .data_word_only, .data_offset, .data_line,
		.wdata_word (data_line[cache_pkg::WORD_BITS-1:0]),
		.rd_line0, .rd_line1
	);

	mem_burst burst_i (
		.clk, .reset,
		.evict_start, .fill_start, .burst_addr, .evict_line,
		.data_mem, .ready_mem,
		.addr_mem, .wdata_mem, .read_mem, .write_mem,
		.fill_line, .burst_done
	);

endmodule

`default_nettype wire

/* design/cache_fsm.sv */
`default_nettype none

module cache_fsm (
	input  wire                  clk,
	input  wire                  reset,
	input  wire cache_pkg::addr_t addr_up,
	input  wire cache_pkg::word_t data_up,
	input  wire                  read_up,
	input  wire                  write_up,
	input  wire                  hit,
	input  wire cache_pkg::way_t hit_way,
	input  wire cache_pkg::way_t victim_way,
	input  wire                  victim_dirty,
	input  wire cache_pkg::tag_t victim_tag,
	input  wire cache_pkg::line_t rd_line0,
	input  wire cache_pkg::line_t rd_line1,
	input  wire cache_pkg::line_t fill_line,
	input  wire                  burst_done,
	output cache_pkg::word_t     rdata_up,
	output logic                 stall_up,
	output cache_pkg::index_t    lookup_index,
	output logic                 tag_we,
	output cache_pkg::way_t      tag_way,
	output cache_pkg::tag_t      new_tag,
	output logic                 new_dirty,
	output logic                 data_we,
	output cache_pkg::way_t      data_way,
	output logic                 data_word_only,
	output cache_pkg::offset_t   data_offset,
	output cache_pkg::line_t     data_line,
	output logic                 evict_start,
	output logic                 fill_start,
	output cache_pkg::addr_t     burst_addr,
	output cache_pkg::line_t     evict_line
);

	cache_pkg::ctrl_state_e state;
	cache_pkg::addr_t       req_addr;
	cache_pkg::word_t       req_data;
	logic                   req_write;
	cache_pkg::way_t        vway_q;		// victim chosen at lookup
	cache_pkg::index_t      req_index;
	cache_pkg::offset_t     req_offset;
	cache_pkg::line_t       hit_line;
	cache_pkg::line_t       merged_line;

	assign req_offset = req_addr[cache_pkg::OFFSET_BITS-1:0];
	assign req_index  = req_addr[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS];
	assign new_tag    = req_addr[cache_pkg::ADDR_BITS-1 -: cache_pkg::TAG_BITS];

	// arrays see the incoming index while idle so lookup data is ready next cycle
	assign lookup_index = (state == cache_pkg::IDLE) ?
		addr_up[cache_pkg::OFFSET_BITS +: cache_pkg::INDEX_BITS] : req_index;

	assign hit_line   = hit_way ? rd_line1 : rd_line0;
	assign evict_line = victim_way ? rd_line1 : rd_line0;

	// fill data with the write word dropped in on a write miss
	always_comb begin
		merged_line = fill_line;
		if (req_write)
			merged_line[req_offset*cache_pkg::WORD_BITS +: cache_pkg::WORD_BITS] = req_data;
	end

	assign tag_we         = (state == cache_pkg::LOOKUP && hit) || state == cache_pkg::INSTALL;
	assign data_we        = (state == cache_pkg::LOOKUP && hit && req_write) ||
		state == cache_pkg::INSTALL;
	assign tag_way        = (state == cache_pkg::INSTALL) ? vway_q : hit_way;
	assign data_way       = tag_way;
	assign new_dirty      = req_write;	// install of a read miss leaves the line clean
	assign data_word_only = (state == cache_pkg::LOOKUP);
	assign data_offset    = req_offset;
	assign data_line      = (state == cache_pkg::INSTALL) ? merged_line :
		{cache_pkg::LINE_WORDS{req_data}};

	assign evict_start = state == cache_pkg::LOOKUP && !hit && victim_dirty;
	assign fill_start  = (state == cache_pkg::LOOKUP && !hit && !victim_dirty) ||
		(state == cache_pkg::EVICT && burst_done);
	assign burst_addr  = evict_start ?
		{victim_tag, req_index, {cache_pkg::OFFSET_BITS{1'b0}}} :
		{new_tag, req_index, {cache_pkg::OFFSET_BITS{1'b0}}};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state     <= cache_pkg::IDLE;
			stall_up  <= 1'b0;
			rdata_up  <= '0;
			req_write <= 1'b0;
		end else begin
			case (state)
				cache_pkg::IDLE: begin
					if (read_up || write_up) begin
						state     <= cache_pkg::LOOKUP;
						stall_up  <= 1'b1;
						req_write <= !read_up;	// read wins a tie
					end
				end
				cache_pkg::LOOKUP: begin
					if (hit) begin
						state    <= cache_pkg::IDLE;
						stall_up <= 1'b0;
						if (!req_write)
							rdata_up <= hit_line[req_offset*cache_pkg::WORD_BITS +:
								cache_pkg::WORD_BITS];
					end else if (victim_dirty) begin
						state <= cache_pkg::EVICT;
					end else begin
						state <= cache_pkg::FILL;
					end
				end
				cache_pkg::EVICT: if (burst_done) state <= cache_pkg::FILL;
				cache_pkg::FILL: if (burst_done) state <= cache_pkg::INSTALL;
				cache_pkg::INSTALL: begin
					state    <= cache_pkg::IDLE;
					stall_up <= 1'b0;
					if (!req_write)
						rdata_up <= merged_line[req_offset*cache_pkg::WORD_BITS +:
							cache_pkg::WORD_BITS];
				end
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	// request payload
	always_ff @(posedge clk) begin
		if (state == cache_pkg::IDLE && (read_up || write_up)) begin
			req_addr <= addr_up;
			req_data <= data_up;
		end
		if (state == cache_pkg::LOOKUP)
			vway_q <= victim_way;
	end

endmodule

`default_nettype wire

/* design/mem_burst.sv */
`default_nettype none

module mem_burst (
	input  wire                   clk,
	input  wire                   reset,
	input  wire                   evict_start,
	input  wire                   fill_start,
	input  wire cache_pkg::addr_t burst_addr,
	input  wire cache_pkg::line_t evict_line,
	input  wire cache_pkg::word_t data_mem,
	input  wire                   ready_mem,
	output cache_pkg::addr_t      addr_mem,
	output cache_pkg::word_t      wdata_mem,
	output logic                  read_mem,
	output logic                  write_mem,
	output cache_pkg::line_t      fill_line,
	output logic                  burst_done
);

	cache_pkg::offset_t count;		// words moved so far
	cache_pkg::line_t   shift_q;
	logic               xfer;
	logic               last;

	assign xfer = (read_mem || write_mem) && ready_mem;
	assign last = xfer && count == '1;

	assign wdata_mem = shift_q[cache_pkg::WORD_BITS-1:0];
	assign fill_line = shift_q;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			read_mem   <= 1'b0;
			write_mem  <= 1'b0;
			count      <= '0;
			burst_done <= 1'b0;
		end else begin
			burst_done <= last;
			if (evict_start) begin
				write_mem <= 1'b1;
				count     <= '0;
			end else if (fill_start) begin
				read_mem <= 1'b1;
				count    <= '0;
			end else if (xfer) begin
				count <= count + 1'b1;
				if (last) begin
					read_mem  <= 1'b0;
					write_mem <= 1'b0;
				end
			end
		end
	end

	// words enter at the top, so word 0 ends up low after four
	always_ff @(posedge clk) begin
		if (evict_start || fill_start)
			addr_mem <= {burst_addr[cache_pkg::ADDR_BITS-1:cache_pkg::OFFSET_BITS],
				{cache_pkg::OFFSET_BITS{1'b0}}};
		if (evict_start)
			shift_q <= evict_line;
		else if (read_mem && ready_mem)
			shift_q <= {data_mem, shift_q[cache_pkg::LINE_BITS-1:cache_pkg::WORD_BITS]};
		else if (write_mem && ready_mem)
			shift_q <= shift_q >> cache_pkg::WORD_BITS;	// next word to wdata_mem
	end

endmodule

`default_nettype wire

/* design/data_store.sv */
`default_nettype none

module data_store (
	input  wire                    clk,
	input  wire cache_pkg::index_t lookup_index,
	input  wire                    data_we,
	input  wire cache_pkg::way_t   data_way,
	input  wire                    data_word_only,
	input  wire cache_pkg::offset_t data_offset,
	input  wire cache_pkg::line_t  data_line,
	input  wire cache_pkg::word_t  wdata_word,
	output cache_pkg::line_t       rd_line0,
	output cache_pkg::line_t       rd_line1
);

	cache_pkg::line_t line_ram [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
	cache_pkg::line_t rd_q [cache_pkg::NUM_WAYS];

	always_ff @(posedge clk) begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (data_we && data_way == w) begin
				if (data_word_only)
					line_ram[w][lookup_index][data_offset*cache_pkg::WORD_BITS +:
						cache_pkg::WORD_BITS] <= wdata_word;	// hit write
				else
					line_ram[w][lookup_index] <= data_line;	// fill install
			end
			// old contents on a same-cycle write
			rd_q[w] <= line_ram[w][lookup_index];
		end
	end

	assign rd_line0 = rd_q[0];
	assign rd_line1 = rd_q[1];

endmodule

`default_nettype wire

/* design/tag_store.sv */
`default_nettype none

module tag_store (
	input  wire                   clk,
	input  wire                   reset,
	input  wire cache_pkg::index_t lookup_index,
	input  wire cache_pkg::tag_t  lookup_tag,
	input  wire                   tag_we,
	input  wire cache_pkg::way_t  tag_way,
	input  wire cache_pkg::tag_t  new_tag,
	input  wire                   new_dirty,
	output logic                  hit,
	output cache_pkg::way_t       hit_way,
	output cache_pkg::way_t       victim_way,
	output logic                  victim_dirty,
	output cache_pkg::tag_t       victim_tag
);

	cache_pkg::tag_t   tag_ram [cache_pkg::NUM_WAYS][cache_pkg::NUM_SETS];
	cache_pkg::tag_t   rd_tag [cache_pkg::NUM_WAYS];
	cache_pkg::index_t idx_q;		// index behind rd_tag

	logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] valid_q;
	logic [cache_pkg::NUM_SETS-1:0][cache_pkg::NUM_WAYS-1:0] dirty_q;
	logic [cache_pkg::NUM_SETS-1:0] lru_q;	// names the way to replace

	logic [cache_pkg::NUM_WAYS-1:0] way_valid;
	logic [cache_pkg::NUM_WAYS-1:0] way_match;
	logic                           keep_dirty;

	// tag rams, registered read
	always_ff @(posedge clk) begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++) begin
			if (tag_we && tag_way == w)
				tag_ram[w][lookup_index] <= new_tag;
			rd_tag[w] <= tag_ram[w][lookup_index];
		end
		idx_q <= lookup_index;
	end

	assign way_valid = valid_q[idx_q];

	always_comb begin
		for (int w = 0; w < cache_pkg::NUM_WAYS; w++)
			way_match[w] = way_valid[w] && (rd_tag[w] == lookup_tag);
	end

	assign hit     = |way_match;
	assign hit_way = way_match[1];

	// empty ways first, then lru
	always_comb begin
		if (!way_valid[0])
			victim_way = 1'b0;
		else if (!way_valid[1])
			victim_way = 1'b1;
		else
			victim_way = lru_q[idx_q];
	end

	assign victim_dirty = way_valid[victim_way] && dirty_q[idx_q][victim_way];
	assign victim_tag   = rd_tag[victim_way];

	// rewriting the line already there (a hit) keeps its dirty bit
	assign keep_dirty = way_valid[tag_way] && dirty_q[idx_q][tag_way] &&
		(rd_tag[tag_way] == new_tag);

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q   <= '0;
		end else if (tag_we) begin
			valid_q[lookup_index][tag_way] <= 1'b1;
			dirty_q[lookup_index][tag_way] <= new_dirty || keep_dirty;
			lru_q[lookup_index]            <= !tag_way;	// other way goes next
		end
	end

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

package cache_pkg;

	// word and line geometry
	localparam int WORD_BITS   = 32;
	localparam int ADDR_BITS   = 32;	// word address
	localparam int LINE_WORDS  = 4;
	localparam int OFFSET_BITS = $clog2(LINE_WORDS);
	localparam int LINE_BITS   = LINE_WORDS * WORD_BITS;

	// two ways of 64 sets each
	localparam int NUM_SETS    = 64;
	localparam int INDEX_BITS  = $clog2(NUM_SETS);
	localparam int NUM_WAYS    = 2;

	// what is left of the address once index and offset are taken
	localparam int TAG_BITS    = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

	typedef logic [WORD_BITS-1:0]   word_t;
	typedef logic [ADDR_BITS-1:0]   addr_t;
	typedef logic [LINE_BITS-1:0]   line_t;	// word 0 in the low bits

	typedef logic [TAG_BITS-1:0]    tag_t;
	typedef logic [INDEX_BITS-1:0]  index_t;
	typedef logic [OFFSET_BITS-1:0] offset_t;

	typedef logic                   way_t;

	// controller states
	typedef enum logic [2:0] {
		IDLE,		// waiting for a request
		LOOKUP,		// tag and data arrays valid
		EVICT,		// dirty victim going out
		FILL,		// line coming in
		INSTALL		// filled line written into the victim way
	} ctrl_state_e;

endpackage

`default_nettype wire
